// ==== hdl/rvExecPkg.sv ====
`default_nettype none

package rvExecPkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = 8;
    localparam int APB_ADDR_W  = 4;

    // APB register map
    localparam logic [APB_ADDR_W-1:0] CTRL_ADDR      = 4'h0;
    localparam logic [APB_ADDR_W-1:0] RETIRED_ADDR   = 4'h4;
    localparam logic [APB_ADDR_W-1:0] PEEK_SEL_ADDR  = 4'h8;
    localparam logic [APB_ADDR_W-1:0] PEEK_DATA_ADDR = 4'hC;

    typedef enum logic [2:0] {
        OP_ALU, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL, OP_JALR
    } instrClass_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
    } aluOp_e;

    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } brCond_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwdSel_e;

    typedef enum logic [1:0] {
        RES_ALU, RES_LOAD, RES_LINK
    } resultSrc_e;

    typedef struct packed {
        instrClass_e            cls;
        aluOp_e                 aluOp;
        brCond_e                brCond;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   useImm;
        logic [XLEN-1:0]        imm;    // already sign extended
        logic [XLEN-1:0]        pc;
    } decodedInstr_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [XLEN-1:0]       pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apbRsp_t;

endpackage

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                                clk,
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    rs1Addr_i,
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    rs2Addr_i,
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    dbgAddr_i,
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    wrAddr_i,
    input  logic                                wrEn_i,
    input  logic [rvExecPkg::XLEN-1:0]          wrData_i,
    output logic [rvExecPkg::XLEN-1:0]          rs1Data_o,
    output logic [rvExecPkg::XLEN-1:0]          rs2Data_o,
    output logic [rvExecPkg::XLEN-1:0]          dbgData_o
);

    logic [rvExecPkg::XLEN-1:0] regs [2**rvExecPkg::REG_ADDR_W];

    // x0 reads zero, same-cycle write wins
    function automatic logic [rvExecPkg::XLEN-1:0] readReg(
        input logic [rvExecPkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
            return '0;
        if (wrEn_i && addr == wrAddr_i)
            return wrData_i;
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data_o = readReg(rs1Addr_i);
        rs2Data_o = readReg(rs2Addr_i);
        dbgData_o = readReg(dbgAddr_i);
    end

    always_ff @(posedge clk) begin
        if (wrEn_i && wrAddr_i != '0)
            regs[wrAddr_i] <= wrData_i;
    end

    // the pipeline filters rd == 0 long before writeback
    assert property (@(posedge clk) !(wrEn_i && wrAddr_i == '0))
        else $error("regFile: write to x0 requested");

endmodule

`default_nettype wire

// ==== hdl/forwardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    rs1E_i,
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    rs2E_i,
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    rdM_i,
    input  logic [rvExecPkg::REG_ADDR_W-1:0]    rdW_i,
    input  logic                                wrValidM_i,
    input  logic                                wrValidW_i,
    output rvExecPkg::fwdSel_e                  fwdA_o,
    output rvExecPkg::fwdSel_e                  fwdB_o
);

    function automatic rvExecPkg::fwdSel_e pickSrc(
        input logic [rvExecPkg::REG_ADDR_W-1:0] rs
    );
        if (rs == '0)
            return rvExecPkg::FWD_REG;     // x0 is never forwarded
        if (wrValidM_i && rdM_i == rs)
            return rvExecPkg::FWD_MEM;     // youngest result first
        if (wrValidW_i && rdW_i == rs)
            return rvExecPkg::FWD_WB;
        return rvExecPkg::FWD_REG;
    endfunction

    // load data is ready in M already, so load-use needs no bubble
    always_comb begin
        fwdA_o = pickSrc(rs1E_i);
        fwdB_o = pickSrc(rs2E_i);
    end

endmodule

`default_nettype wire

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  rvExecPkg::decodedInstr_t        instrE_i,
    input  logic [rvExecPkg::XLEN-1:0]      rs1Val_i,
    input  logic [rvExecPkg::XLEN-1:0]      rs2Val_i,
    input  logic [rvExecPkg::XLEN-1:0]      memResult_i,
    input  logic [rvExecPkg::XLEN-1:0]      wbResult_i,
    input  rvExecPkg::fwdSel_e              fwdA_i,
    input  rvExecPkg::fwdSel_e              fwdB_i,
    output logic [rvExecPkg::XLEN-1:0]      aluResult_o,
    output logic [rvExecPkg::XLEN-1:0]      storeData_o,
    output rvExecPkg::redirect_t            redirect_o
);

    logic [rvExecPkg::XLEN-1:0] srcA, srcB, rs2Fwd, aluOut, effAddr;
    logic                       condOk;

    function automatic logic [rvExecPkg::XLEN-1:0] fwdMux(
        input rvExecPkg::fwdSel_e          sel,
        input logic [rvExecPkg::XLEN-1:0]  regVal
    );
        case (sel)
            rvExecPkg::FWD_MEM: return memResult_i;
            rvExecPkg::FWD_WB:  return wbResult_i;
            default:            return regVal;
        endcase
    endfunction

    always_comb begin
        srcA    = fwdMux(fwdA_i, rs1Val_i);
        rs2Fwd  = fwdMux(fwdB_i, rs2Val_i);
        srcB    = instrE_i.useImm ? instrE_i.imm : rs2Fwd;
        effAddr = srcA + instrE_i.imm;  // loads, stores, jalr
    end

    always_comb begin
        case (instrE_i.aluOp)
            rvExecPkg::SUB:  aluOut = srcA - srcB;
            rvExecPkg::AND:  aluOut = srcA & srcB;
            rvExecPkg::OR:   aluOut = srcA | srcB;
            rvExecPkg::XOR:  aluOut = srcA ^ srcB;
            rvExecPkg::SLT:  aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            rvExecPkg::SLTU: aluOut = {31'd0, srcA < srcB};
            rvExecPkg::SLL:  aluOut = srcA << srcB[4:0];
            rvExecPkg::SRL:  aluOut = srcA >> srcB[4:0];
            rvExecPkg::SRA:  aluOut = $signed(srcA) >>> srcB[4:0];
            default:         aluOut = srcA + srcB;
        endcase
    end

    // branches compare the two register operands, never the immediate
    always_comb begin
        case (instrE_i.brCond)
            rvExecPkg::BEQ:  condOk = srcA == rs2Fwd;
            rvExecPkg::BNE:  condOk = srcA != rs2Fwd;
            rvExecPkg::BLT:  condOk = $signed(srcA) < $signed(rs2Fwd);
            rvExecPkg::BGE:  condOk = $signed(srcA) >= $signed(rs2Fwd);
            rvExecPkg::BLTU: condOk = srcA < rs2Fwd;
            rvExecPkg::BGEU: condOk = srcA >= rs2Fwd;
            default:         condOk = 1'b0;
        endcase
    end

    always_comb begin
        if (instrE_i.cls == rvExecPkg::OP_LOAD || instrE_i.cls == rvExecPkg::OP_STORE)
            aluResult_o = effAddr;
        else
            aluResult_o = aluOut;
        storeData_o = rs2Fwd;

        redirect_o.taken = (instrE_i.cls == rvExecPkg::OP_BRANCH && condOk)
                         || instrE_i.cls == rvExecPkg::OP_JAL
                         || instrE_i.cls == rvExecPkg::OP_JALR;
        if (instrE_i.cls == rvExecPkg::OP_JALR)
            redirect_o.target = {effAddr[rvExecPkg::XLEN-1:1], 1'b0};
        else
            redirect_o.target = instrE_i.pc + instrE_i.imm;
    end

endmodule

`default_nettype wire

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  logic                            clk,
    input  logic [rvExecPkg::XLEN-1:0]      addr_i,
    input  logic                            wrEn_i,
    input  logic [rvExecPkg::XLEN-1:0]      wrData_i,
    output logic [rvExecPkg::XLEN-1:0]      rdData_o
);

    logic [rvExecPkg::XLEN-1:0]         mem [rvExecPkg::DMEM_WORDS];
    logic [rvExecPkg::DMEM_ADDR_W-1:0]  wordAddr;

    assign wordAddr = addr_i[rvExecPkg::DMEM_ADDR_W+1:2];   // byte to word index
    assign rdData_o = mem[wordAddr];   // read in the same cycle

    always_ff @(posedge clk) begin
        if (wrEn_i)
            mem[wordAddr] <= wrData_i;
    end

    // word-only stores, the two low bits would otherwise be dropped
    assert property (@(posedge clk) wrEn_i |-> addr_i[1:0] == 2'b00)
        else $error("dataMem: misaligned store to %h", addr_i);

endmodule

`default_nettype wire

// ==== hdl/execCtrlRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module execCtrlRegs (
    input  logic                                clk,
    input  logic                                arstN_i,
    input  rvExecPkg::apbReq_t                  apbReq_i,
    output rvExecPkg::apbRsp_t                  apbRsp_o,
    input  logic                                retirePulse_i,
    input  logic [rvExecPkg::XLEN-1:0]          dbgData_i,
    output logic [rvExecPkg::REG_ADDR_W-1:0]    dbgAddr_o,
    output logic                                halt_o
);

    logic                               access, addrOk, roWrite, slvErr, wrAccess;
    logic                               halt;
    logic [rvExecPkg::XLEN-1:0]         retired;
    logic [rvExecPkg::REG_ADDR_W-1:0]   peekSel;
    logic [rvExecPkg::XLEN-1:0]         rdData;

    assign access  = apbReq_i.psel & apbReq_i.penable;
    assign addrOk  = apbReq_i.paddr inside {rvExecPkg::CTRL_ADDR, rvExecPkg::RETIRED_ADDR,
                                            rvExecPkg::PEEK_SEL_ADDR, rvExecPkg::PEEK_DATA_ADDR};
    assign roWrite = apbReq_i.pwrite && (apbReq_i.paddr == rvExecPkg::RETIRED_ADDR
                                      || apbReq_i.paddr == rvExecPkg::PEEK_DATA_ADDR);
    assign slvErr   = access & (!addrOk | roWrite);
    assign wrAccess = access & apbReq_i.pwrite & !slvErr;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            halt    <= 1'b0;
            retired <= '0;
            peekSel <= '0;
        end else begin
            if (wrAccess && apbReq_i.paddr == rvExecPkg::CTRL_ADDR)
                halt <= apbReq_i.pwdata[0];
            if (wrAccess && apbReq_i.paddr == rvExecPkg::PEEK_SEL_ADDR)
                peekSel <= apbReq_i.pwdata[rvExecPkg::REG_ADDR_W-1:0];
            if (retirePulse_i)
                retired <= retired + 1'b1;    // wraps
        end
    end

    always_comb begin
        case (apbReq_i.paddr)
            rvExecPkg::CTRL_ADDR:      rdData = {31'd0, halt};
            rvExecPkg::RETIRED_ADDR:   rdData = retired;
            rvExecPkg::PEEK_SEL_ADDR:  rdData = {27'd0, peekSel};
            rvExecPkg::PEEK_DATA_ADDR: rdData = dbgData_i;
            default:                   rdData = '0;
        endcase
    end

    assign apbRsp_o.prdata  = rdData;
    assign apbRsp_o.pready  = 1'b1;     // no wait states
    assign apbRsp_o.pslverr = slvErr;

    assign dbgAddr_o = peekSel;
    assign halt_o    = halt;

    // the master must never raise penable outside a selected transfer
    assert property (@(posedge clk) disable iff (!arstN_i)
        apbReq_i.penable |-> apbReq_i.psel)
        else $error("execCtrlRegs: penable without psel");

endmodule

`default_nettype wire

// ==== hdl/rvExecCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvExecCore (
    input  logic                        clk,
    input  logic                        arstN_i,
    input  logic                        instrValid_i,
    input  rvExecPkg::decodedInstr_t    instr_i,
    output logic                        issueReady_o,
    output rvExecPkg::redirect_t        redirect_o,
    output logic                        retireValid_o,
    output rvExecPkg::retire_t          retire_o,
    input  rvExecPkg::apbReq_t          apbReq_i,
    output rvExecPkg::apbRsp_t          apbRsp_o
);

    typedef struct packed {
        logic                       valid;
        rvExecPkg::decodedInstr_t   instr;
    } eStage_t;

    typedef struct packed {
        logic                               valid;
        logic                               wrEn;
        logic                               isStore;
        rvExecPkg::resultSrc_e              resSrc;
        logic [rvExecPkg::REG_ADDR_W-1:0]   rd;
        logic [rvExecPkg::XLEN-1:0]         aluRes;   // also the memory address
        logic [rvExecPkg::XLEN-1:0]         link;
        logic [rvExecPkg::XLEN-1:0]         storeData;
    } mStage_t;

    typedef struct packed {
        logic                               valid;
        logic                               wrEn;
        logic [rvExecPkg::REG_ADDR_W-1:0]   rd;
        logic [rvExecPkg::XLEN-1:0]         data;
    } wStage_t;

    eStage_t                            eStage;
    mStage_t                            mStage;
    wStage_t                            wStage;
    logic                               halt, accept, writesReg, wrValidM, wrValidW;
    logic [rvExecPkg::REG_ADDR_W-1:0]   dbgAddr;
    logic [rvExecPkg::XLEN-1:0]         rs1Val, rs2Val, dbgData, linkE;
    logic [rvExecPkg::XLEN-1:0]         aluResult, storeData, memRdData, memResult;
    rvExecPkg::fwdSel_e                 fwdA, fwdB;
    rvExecPkg::resultSrc_e              resSrcE;
    rvExecPkg::redirect_t               exRedirect;

    assign issueReady_o = !halt;
    assign accept       = instrValid_i & issueReady_o;
    assign linkE        = eStage.instr.pc + 32'd4;
    assign wrValidM     = mStage.valid & mStage.wrEn;
    assign wrValidW     = wStage.valid & wStage.wrEn;

    // result source and register write for the instruction in E
    always_comb begin
        resSrcE   = rvExecPkg::RES_ALU;
        writesReg = 1'b0;
        case (eStage.instr.cls)
            rvExecPkg::OP_ALU: begin
                writesReg = 1'b1;
            end
            rvExecPkg::OP_LOAD: begin
                resSrcE   = rvExecPkg::RES_LOAD;
                writesReg = 1'b1;
            end
            rvExecPkg::OP_JAL, rvExecPkg::OP_JALR: begin
                resSrcE   = rvExecPkg::RES_LINK;
                writesReg = 1'b1;
            end
            default: ;
        endcase
        writesReg = writesReg && eStage.instr.rd != '0;
    end

    always_comb begin
        case (mStage.resSrc)
            rvExecPkg::RES_LOAD: memResult = memRdData;
            rvExecPkg::RES_LINK: memResult = mStage.link;
            default:             memResult = mStage.aluRes;
        endcase
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            eStage <= '0;
            mStage <= '0;
            wStage <= '0;
        end else begin
            eStage.valid <= accept;
            if (accept)
                eStage.instr <= instr_i;

            mStage.valid     <= eStage.valid;
            mStage.wrEn      <= eStage.valid & writesReg;
            mStage.isStore   <= eStage.valid && eStage.instr.cls == rvExecPkg::OP_STORE;
            mStage.resSrc    <= resSrcE;
            mStage.rd        <= eStage.instr.rd;
            mStage.aluRes    <= aluResult;
            mStage.link      <= linkE;
            mStage.storeData <= storeData;

            wStage.valid <= mStage.valid;
            wStage.wrEn  <= mStage.wrEn;
            wStage.rd    <= mStage.rd;
            wStage.data  <= memResult;
        end
    end

    regFile regFile_inst (
        .clk        (clk),
        .rs1Addr_i  (eStage.instr.rs1),
        .rs2Addr_i  (eStage.instr.rs2),
        .dbgAddr_i  (dbgAddr),
        .wrAddr_i   (wStage.rd),
        .wrEn_i     (wrValidW),
        .wrData_i   (wStage.data),
        .rs1Data_o  (rs1Val),
        .rs2Data_o  (rs2Val),
        .dbgData_o  (dbgData)
    );

    forwardUnit forwardUnit_inst (
        .rs1E_i     (eStage.instr.rs1),
        .rs2E_i     (eStage.instr.rs2),
        .rdM_i      (mStage.rd),
        .rdW_i      (wStage.rd),
        .wrValidM_i (wrValidM),
        .wrValidW_i (wrValidW),
        .fwdA_o     (fwdA),
        .fwdB_o     (fwdB)
    );

    execUnit execUnit_inst (
        .instrE_i    (eStage.instr),
        .rs1Val_i    (rs1Val),
        .rs2Val_i    (rs2Val),
        .memResult_i (memResult),
        .wbResult_i  (wStage.data),
        .fwdA_i      (fwdA),
        .fwdB_i      (fwdB),
        .aluResult_o (aluResult),
        .storeData_o (storeData),
        .redirect_o  (exRedirect)
    );

    dataMem dataMem_inst (
        .clk      (clk),
        .addr_i   (mStage.aluRes),
        .wrEn_i   (mStage.valid & mStage.isStore),
        .wrData_i (mStage.storeData),
        .rdData_o (memRdData)
    );

    execCtrlRegs execCtrlRegs_inst (
        .clk           (clk),
        .arstN_i       (arstN_i),
        .apbReq_i      (apbReq_i),
        .apbRsp_o      (apbRsp_o),
        .retirePulse_i (retireValid_o),
        .dbgData_i     (dbgData),
        .dbgAddr_o     (dbgAddr),
        .halt_o        (halt)
    );

    // redirect only from a live E slot
    assign redirect_o.taken  = exRedirect.taken & eStage.valid;
    assign redirect_o.target = exRedirect.target;

    assign retireValid_o = wrValidW;
    assign retire_o      = '{rd: wStage.rd, data: wStage.data};

    // each retire carries the rd accepted three edges earlier and never x0
    assert property (@(posedge clk) disable iff (!arstN_i)
        retireValid_o |-> retire_o.rd != '0 && $past(accept, 3)
                          && retire_o.rd == $past(instr_i.rd, 3))
        else $error("rvExecCore: retire to x0 or not matching an issued rd");

endmodule

`default_nettype wire

// ==== test/clkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkGen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;   // 40 ns period
    end

endmodule

`default_nettype wire

// ==== test/rvExecCore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvExecCore_tb;

    logic                       clk, arstN, instrValid, issueReady, retireValid;
    rvExecPkg::decodedInstr_t   instr;
    rvExecPkg::redirect_t       redirect;
    rvExecPkg::retire_t         retireOut;
    rvExecPkg::apbReq_t         apbReq;
    rvExecPkg::apbRsp_t         apbRsp;

    int                         seed;
    int                         aluN = 200;
    int                         memN = 30;     // groups of four instructions
    int                         brN = 60;      // alu + branch pairs
    int                         haltN = 24;
    int                         cycleLimit, cycles = 0;
    int                         checkCount = 0, errorCount = 0, testCount = 0, testErrStart;
    int                         issuedCount = 0, modelRetired = 0;
    string                      curTest = "reset";
    logic [31:0]                modelRegs [32];
    logic [31:0]                modelMem [256];
    logic [7:0]                 storedIdx [$];
    rvExecPkg::retire_t         expRetire [$];
    rvExecPkg::retire_t         expHead;
    rvExecPkg::redirect_t       expRedir;
    logic                       redirPending;
    logic [31:0]                nextPc;

    clkGen clkGen_inst (.clk_o(clk));

    rvExecCore rvExecCore_inst (
        .clk           (clk),
        .arstN_i       (arstN),
        .instrValid_i  (instrValid),
        .instr_i       (instr),
        .issueReady_o  (issueReady),
        .redirect_o    (redirect),
        .retireValid_o (retireValid),
        .retire_o      (retireOut),
        .apbReq_i      (apbReq),
        .apbRsp_o      (apbRsp)
    );

    task automatic checkEq(input string what, input logic [63:0] expVal,
                           input logic [63:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("Fail %s %s: expected %0h, actual %0h", curTest, what, expVal, actVal);
        end
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] randImm12();
        logic [11:0] v;
        v = 12'($random(seed));
        return {{20{v[11]}}, v};
    endfunction

    function automatic rvExecPkg::decodedInstr_t mkInstr(input rvExecPkg::instrClass_e cls,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
        input logic [31:0] imm);
        rvExecPkg::decodedInstr_t ins;
        ins        = '0;
        ins.cls    = cls;
        ins.aluOp  = rvExecPkg::ADD;
        ins.rs1    = rs1;
        ins.rs2    = rs2;
        ins.rd     = rd;
        ins.useImm = 1'b1;
        ins.imm    = imm;
        return ins;
    endfunction

    // few registers, so most operands hit the M or W stage
    function automatic rvExecPkg::decodedInstr_t randAlu(input int maxReg);
        rvExecPkg::decodedInstr_t ins;
        ins        = mkInstr(rvExecPkg::OP_ALU, 5'(randBelow(maxReg + 1)),
                             5'(randBelow(maxReg + 1)), 5'(randBelow(maxReg + 1)), randImm12());
        ins.aluOp  = rvExecPkg::aluOp_e'(randBelow(10));
        ins.useImm = randBelow(2) == 1;
        return ins;
    endfunction

    function automatic logic [31:0] regVal(input logic [4:0] r);
        return (r == 5'd0) ? 32'd0 : modelRegs[r];
    endfunction

    // executes in program order, returns the redirect expected one cycle later
    function automatic rvExecPkg::redirect_t modelExec(input rvExecPkg::decodedInstr_t ins);
        logic [31:0]            a, b, opB, res, addr;
        rvExecPkg::redirect_t   r;
        rvExecPkg::retire_t     ret;
        a    = regVal(ins.rs1);
        b    = regVal(ins.rs2);
        opB  = ins.useImm ? ins.imm : b;
        addr = a + ins.imm;
        r    = '0;
        case (ins.aluOp)
            rvExecPkg::SUB:  res = a - opB;
            rvExecPkg::AND:  res = a & opB;
            rvExecPkg::OR:   res = a | opB;
            rvExecPkg::XOR:  res = a ^ opB;
            rvExecPkg::SLT:  res = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
            rvExecPkg::SLTU: res = (a < opB) ? 32'd1 : 32'd0;
            rvExecPkg::SLL:  res = a << opB[4:0];
            rvExecPkg::SRL:  res = a >> opB[4:0];
            rvExecPkg::SRA:  res = $signed(a) >>> opB[4:0];
            default:         res = a + opB;
        endcase
        case (ins.cls)
            rvExecPkg::OP_LOAD:  res = modelMem[addr[9:2]];
            rvExecPkg::OP_STORE: modelMem[addr[9:2]] = b;
            rvExecPkg::OP_BRANCH: begin
                case (ins.brCond)
                    rvExecPkg::BEQ:  r.taken = a == b;
                    rvExecPkg::BNE:  r.taken = a != b;
                    rvExecPkg::BLT:  r.taken = $signed(a) < $signed(b);
                    rvExecPkg::BGE:  r.taken = $signed(a) >= $signed(b);
                    rvExecPkg::BLTU: r.taken = a < b;
                    default:         r.taken = a >= b;
                endcase
                r.target = ins.pc + ins.imm;
            end
            rvExecPkg::OP_JAL: begin
                res      = ins.pc + 32'd4;
                r.taken  = 1'b1;
                r.target = ins.pc + ins.imm;
            end
            rvExecPkg::OP_JALR: begin
                res      = ins.pc + 32'd4;
                r.taken  = 1'b1;
                r.target = addr & ~32'd1;
            end
            default: ;
        endcase
        if (ins.cls != rvExecPkg::OP_STORE && ins.cls != rvExecPkg::OP_BRANCH
                && ins.rd != 5'd0) begin
            modelRegs[ins.rd] = res;
            ret.rd   = ins.rd;
            ret.data = res;
            expRetire.push_back(ret);
            modelRetired++;
        end
        return r;
    endfunction

    // returns right at the accepting edge
    task automatic issueInstr(input rvExecPkg::decodedInstr_t ins);
        logic rdy;
        ins.pc = nextPc;
        #2;
        instrValid = 1'b1;
        instr      = ins;
        do begin
            @(negedge clk);
            rdy = issueReady;    // halt only moves at a rising edge
            @(posedge clk);
        end while (!rdy);
        issuedCount++;
        expRedir     = modelExec(ins);
        redirPending = 1'b1;
        nextPc       = expRedir.taken ? expRedir.target : nextPc + 32'd4;
    endtask

    task automatic waitDrain();
        int n;
        #2;
        instrValid = 1'b0;
        n = 0;
        while (expRetire.size() != 0 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (expRetire.size() != 0) begin
            errorCount++;
            $display("%s: %0d retires still missing after drain", curTest, expRetire.size());
        end
        @(posedge clk);
    endtask

    task automatic apbAccess(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        #2;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = wr;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #2;
        apbReq.penable = 1'b1;
        @(negedge clk);
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        checkEq("pready", 1, apbRsp.pready);
        @(posedge clk);
        #2;
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic startTest(input string name);
        curTest      = name;
        testErrStart = errorCount;
        testCount++;
    endtask

    task automatic endTest();
        $display("%s: %s, %0d errors", curTest,
                 (errorCount == testErrStart) ? "ok" : "mismatches", errorCount - testErrStart);
    endtask

    // retire order and the redirect one cycle after each issue
    always @(negedge clk) begin
        if (arstN) begin
            if (retireValid) begin
                if (expRetire.size() == 0) begin
                    errorCount++;
                    $display("%s: retire to x%0d with nothing outstanding", curTest,
                             retireOut.rd);
                end else begin
                    expHead = expRetire.pop_front();
                    checkEq("retire rd", expHead.rd, retireOut.rd);
                    checkEq("retire data", expHead.data, retireOut.data);
                end
            end
            if (redirPending) begin
                checkEq("redirect taken", expRedir.taken, redirect.taken);
                if (expRedir.taken)
                    checkEq("redirect target", expRedir.target, redirect.target);
                redirPending = 1'b0;
            end else if (redirect.taken !== 1'b0) begin
                errorCount++;
                $display("%s: redirect raised with no instruction in execute", curTest);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: run did not end within %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [31:0]                rdata;
        logic                       err;
        int                         idx, ra, rb, kind, held;
        rvExecPkg::decodedInstr_t   ins;

        seed         = 73930;
        cycleLimit   = 4 * (31 + aluN + 4 * memN + 2 * brN + haltN) + 200;
        arstN        = 1'b0;
        instrValid   = 1'b0;
        instr        = '0;
        apbReq       = '0;
        redirPending = 1'b0;
        nextPc       = 32'h0000_1000;
        repeat (10) @(posedge clk);
        #2 arstN = 1'b1;

        startTest("reset");
        @(negedge clk);
        checkEq("issueReady", 1, issueReady);
        checkEq("retireValid", 0, retireValid);
        checkEq("redirect taken", 0, redirect.taken);
        @(posedge clk);
        apbAccess(1'b0, rvExecPkg::RETIRED_ADDR, 32'd0, rdata, err);
        checkEq("RETIRED", 0, rdata);
        apbAccess(1'b0, rvExecPkg::CTRL_ADDR, 32'd0, rdata, err);
        checkEq("CTRL", 0, rdata);
        endTest();

        startTest("aluFwd");
        for (int r = 1; r < 32; r++)
            issueInstr(mkInstr(rvExecPkg::OP_ALU, 5'd0, 5'd0, 5'(r), 32'($random(seed))));
        for (int i = 0; i < aluN; i++)
            issueInstr(randAlu(4));
        waitDrain();
        endTest();

        startTest("loadStore");
        for (int g = 0; g < memN; g++) begin
            ra  = 1 + randBelow(8);
            rb  = 1 + randBelow(8);
            idx = randBelow(256);
            ins = randAlu(8);
            ins.rd = 5'(ra);
            issueInstr(ins);
            storedIdx.push_back(8'(idx));
            issueInstr(mkInstr(rvExecPkg::OP_STORE, 5'd0, 5'(ra), 5'd0, 32'(idx * 4)));
            if (randBelow(2) == 1)
                idx = storedIdx[randBelow(storedIdx.size())];
            issueInstr(mkInstr(rvExecPkg::OP_LOAD, 5'd0, 5'd0, 5'(rb), 32'(idx * 4)));
            ins = randAlu(8);
            ins.rs1 = 5'(rb);    // load-use
            issueInstr(ins);
        end
        waitDrain();
        endTest();

        startTest("branchJump");
        for (int i = 0; i < brN; i++) begin
            issueInstr(randAlu(4));
            kind = i % 8;
            ra   = randBelow(5);
            rb   = (randBelow(4) == 0) ? ra : randBelow(5);
            if (kind < 6) begin
                ins = mkInstr(rvExecPkg::OP_BRANCH, 5'(ra), 5'(rb), 5'd0, randImm12() & ~32'd1);
                ins.brCond = rvExecPkg::brCond_e'(kind);
            end else if (kind == 6) begin
                ins = mkInstr(rvExecPkg::OP_JAL, 5'd0, 5'd0, 5'(randBelow(5)),
                              randImm12() & ~32'd1);
            end else begin
                ins = mkInstr(rvExecPkg::OP_JALR, 5'(ra), 5'd0, 5'(randBelow(5)), randImm12());
            end
            issueInstr(ins);
        end
        waitDrain();
        endTest();

        startTest("halt");
        for (int i = 0; i < 4; i++)
            issueInstr(randAlu(4));
        fork
            begin
                for (int i = 4; i < haltN; i++)
                    issueInstr(randAlu(4));
            end
            begin
                apbAccess(1'b1, rvExecPkg::CTRL_ADDR, 32'd1, rdata, err);
                checkEq("CTRL write pslverr", 0, err);
                checkEq("issueReady while halted", 0, issueReady);
                held = issuedCount;
                repeat (8) @(posedge clk);
                checkEq("retires pending while halted", 0, expRetire.size());
                checkEq("issued while halted", held, issuedCount);
                apbAccess(1'b1, rvExecPkg::CTRL_ADDR, 32'd0, rdata, err);
            end
        join
        waitDrain();
        endTest();

        startTest("apbStatus");
        apbAccess(1'b0, rvExecPkg::RETIRED_ADDR, 32'd0, rdata, err);
        checkEq("RETIRED count", modelRetired, rdata);
        checkEq("RETIRED pslverr", 0, err);
        for (int i = 0; i < 8; i++) begin
            ra = (i == 0) ? 0 : randBelow(32);
            apbAccess(1'b1, rvExecPkg::PEEK_SEL_ADDR, 32'(ra), rdata, err);
            apbAccess(1'b0, rvExecPkg::PEEK_SEL_ADDR, 32'd0, rdata, err);
            checkEq("PEEK_SEL readback", ra, rdata);
            apbAccess(1'b0, rvExecPkg::PEEK_DATA_ADDR, 32'd0, rdata, err);
            checkEq("PEEK_DATA", regVal(5'(ra)), rdata);
        end
        apbAccess(1'b0, 4'h2, 32'd0, rdata, err);
        checkEq("unmapped read pslverr", 1, err);
        apbAccess(1'b1, 4'h6, 32'hffff_ffff, rdata, err);
        checkEq("unmapped write pslverr", 1, err);
        apbAccess(1'b1, rvExecPkg::RETIRED_ADDR, 32'h1234, rdata, err);
        checkEq("RETIRED write pslverr", 1, err);
        apbAccess(1'b1, rvExecPkg::PEEK_DATA_ADDR, 32'h5678, rdata, err);
        checkEq("PEEK_DATA write pslverr", 1, err);
        apbAccess(1'b0, rvExecPkg::RETIRED_ADDR, 32'd0, rdata, err);
        checkEq("RETIRED after bad write", modelRetired, rdata);
        apbAccess(1'b0, rvExecPkg::CTRL_ADDR, 32'd0, rdata, err);
        checkEq("CTRL after bad writes", 0, rdata);
        endTest();

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rvExecCore.f ====
hdl/rvExecPkg.sv
hdl/regFile.sv
hdl/forwardUnit.sv
hdl/execUnit.sv
hdl/dataMem.sv
hdl/execCtrlRegs.sv
hdl/rvExecCore.sv
test/clkGen.sv
test/rvExecCore_tb.sv

// ==== Makefile ====
TB_BIN := obj_dir/VrvExecCore_tb

all: run

$(TB_BIN): rvExecCore.f $(wildcard hdl/*.sv test/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f rvExecCore.f --top-module rvExecCore_tb -Mdir obj_dir

run: $(TB_BIN)
	@out="$$(./$(TB_BIN))"; echo "$$out"; \
		echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

.PHONY: all run clean
